// ==== build.f ====
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_req_queue.sv
hw/dcache_miss_fsm.sv
hw/dcache_line_buf.sv
hw/dcache_ctrl_top.sv
tests/dcache_clk_gen.sv
tests/dcache_asserts.sv
tests/dcache_tb.sv

// ==== hw/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// ============================================================
// data cache controller sizing
// ============================================================

// byte address width on the cpu and bus sides
`define DC_ADDR_W 32

// bytes in one cache line
`define DC_LINE_BYTES 16

// bytes moved by one bus transaction, always half a line
`define DC_HALF_BYTES 8

// cpu request queue slots
`define DC_QUEUE_DEPTH 4

// transaction id width, shared by cpu and bus
`define DC_TID_W 4

`endif

// ==== hw/dcache_ctrl_top.sv ====
`timescale 1ns/1ps

module dcache_ctrl_top import dcache_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic dce_i,
	// cpu side
	input logic cpu_cyc_i,
	input logic cpu_we_i,
	input adr_t cpu_adr_i,
	input line_sel_t cpu_sel_i,
	input line_t cpu_dat_i,
	input tid_t cpu_tid_i,
	input logic cpu_cacheable_i,
	output logic cpu_busy_o,
	output logic cpu_ack_o,
	output tid_t cpu_tid_o,
	output line_t cpu_dat_o,
	// cache array side
	output adr_t lookup_adr_o,
	input logic hit_i,
	input logic modified_i,
	input line_t cache_rd_dat_i,
	input adr_t victim_tag_i,
	input line_t victim_dat_i,
	output logic cache_wr_o,
	output line_t cache_wr_dat_o,
	output adr_t cache_wr_adr_o,
	output logic cache_load_o,
	output logic dump_ack_o,
	// system bus side
	output logic bus_cyc_o,
	output logic bus_we_o,
	output adr_t bus_adr_o,
	output half_sel_t bus_sel_o,
	output half_t bus_dat_o,
	output tid_t bus_tid_o,
	input logic bus_ack_i,
	input tid_t bus_tid_i,
	input half_t bus_dat_i
);

	// queue head
	logic head_v, head_we, head_cacheable, pop;
	adr_t head_adr;
	line_sel_t head_sel;
	line_t head_dat;
	tid_t head_tid;

	// fsm to line buffer
	logic issue_half, skip_lo, skip_hi, svc_start;
	logic fill, finish, hit_ack, halves_done;
	logic svc_we;
	line_sel_t svc_sel;
	line_t svc_dat, hit_line;
	adr_t svc_adr;
	tid_t svc_tid;

	dcache_req_queue u_queue (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cpu_cyc_i(cpu_cyc_i),
		.cpu_we_i(cpu_we_i),
		.cpu_adr_i(cpu_adr_i),
		.cpu_sel_i(cpu_sel_i),
		.cpu_dat_i(cpu_dat_i),
		.cpu_tid_i(cpu_tid_i),
		.cpu_cacheable_i(cpu_cacheable_i),
		.pop_i(pop),
		.cpu_busy_o(cpu_busy_o),
		.head_v_o(head_v),
		.head_we_o(head_we),
		.head_adr_o(head_adr),
		.head_sel_o(head_sel),
		.head_dat_o(head_dat),
		.head_tid_o(head_tid),
		.head_cacheable_o(head_cacheable)
	);

	dcache_miss_fsm u_fsm (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.dce_i(dce_i),
		.head_v_i(head_v),
		.head_we_i(head_we),
		.head_adr_i(head_adr),
		.head_sel_i(head_sel),
		.head_dat_i(head_dat),
		.head_tid_i(head_tid),
		.head_cacheable_i(head_cacheable),
		.hit_i(hit_i),
		.modified_i(modified_i),
		.cache_rd_dat_i(cache_rd_dat_i),
		.victim_tag_i(victim_tag_i),
		.victim_dat_i(victim_dat_i),
		.halves_done_i(halves_done),
		.pop_o(pop),
		.lookup_adr_o(lookup_adr_o),
		.bus_cyc_o(bus_cyc_o),
		.bus_we_o(bus_we_o),
		.bus_adr_o(bus_adr_o),
		.bus_sel_o(bus_sel_o),
		.bus_dat_o(bus_dat_o),
		.bus_tid_o(bus_tid_o),
		.issue_half_o(issue_half),
		.skip_lo_o(skip_lo),
		.skip_hi_o(skip_hi),
		.svc_start_o(svc_start),
		.dump_ack_o(dump_ack_o),
		.fill_o(fill),
		.finish_o(finish),
		.svc_we_o(svc_we),
		.svc_sel_o(svc_sel),
		.svc_dat_o(svc_dat),
		.svc_adr_o(svc_adr),
		.svc_tid_o(svc_tid),
		.hit_line_o(hit_line),
		.hit_ack_o(hit_ack)
	);

	// the locked head still holds the serviced request's cacheable bit
	dcache_line_buf u_line_buf (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.svc_start_i(svc_start),
		.issue_half_i(issue_half),
		.bus_we_i(bus_we_o),
		.bus_tid_i(bus_tid_o),
		.bus_adr_i(bus_adr_o),
		.skip_lo_i(skip_lo),
		.skip_hi_i(skip_hi),
		.bus_ack_i(bus_ack_i),
		.ack_tid_i(bus_tid_i),
		.bus_rd_dat_i(bus_dat_i),
		.fill_i(fill),
		.finish_i(finish),
		.hit_ack_i(hit_ack),
		.hit_line_i(hit_line),
		.svc_we_i(svc_we),
		.svc_sel_i(svc_sel),
		.svc_dat_i(svc_dat),
		.svc_adr_i(svc_adr),
		.svc_tid_i(svc_tid),
		.cache_rd_dat_i(cache_rd_dat_i),
		.hit_i(hit_i),
		.dce_i(dce_i),
		.cacheable_i(head_cacheable),
		.halves_done_o(halves_done),
		.cpu_ack_o(cpu_ack_o),
		.cpu_tid_o(cpu_tid_o),
		.cpu_dat_o(cpu_dat_o),
		.cache_wr_o(cache_wr_o),
		.cache_load_o(cache_load_o),
		.cache_wr_dat_o(cache_wr_dat_o),
		.cache_wr_adr_o(cache_wr_adr_o)
	);

endmodule

// ==== hw/dcache_line_buf.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_line_buf import dcache_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic svc_start_i,
	input logic issue_half_i,
	input logic bus_we_i,
	input tid_t bus_tid_i,
	input adr_t bus_adr_i,
	input logic skip_lo_i,
	input logic skip_hi_i,
	input logic bus_ack_i,
	input tid_t ack_tid_i,
	input half_t bus_rd_dat_i,
	input logic fill_i,
	input logic finish_i,
	input logic hit_ack_i,
	input line_t hit_line_i,
	input logic svc_we_i,
	input line_sel_t svc_sel_i,
	input line_t svc_dat_i,
	input adr_t svc_adr_i,
	input tid_t svc_tid_i,
	input line_t cache_rd_dat_i,
	input logic hit_i,
	input logic dce_i,
	input logic cacheable_i,
	output logic halves_done_o,
	output logic cpu_ack_o,
	output tid_t cpu_tid_o,
	output line_t cpu_dat_o,
	output logic cache_wr_o,
	output logic cache_load_o,
	output line_t cache_wr_dat_o,
	output adr_t cache_wr_adr_o
);

	localparam int HW = `DC_HALF_BYTES*8;

	// per half completion and outstanding read
	logic [1:0] done_q;
	logic [1:0] pend_q;
	tid_t exp_tid_q [2];
	line_t line_q;

	bus_adr_u iss_u;
	bus_adr_u wr_u;
	logic [1:0] ack_hit;
	line_t merged;

	always_comb begin
		iss_u.flat = bus_adr_i;
		// cache writes are line aligned
		wr_u.flat = svc_adr_i;
		wr_u.f.half = 1'b0;
		wr_u.f.ofs = '0;
		for (int h = 0; h < 2; h++)
			ack_hit[h] = bus_ack_i && pend_q[h] && (exp_tid_q[h] == ack_tid_i);
	end

	// ============================================================
	// half tracking
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			done_q <= 2'b00;
			pend_q <= 2'b00;
		end
		else begin
			if (svc_start_i) begin
				// skipped halves count as done from the start
				done_q <= {skip_hi_i, skip_lo_i};
				pend_q <= 2'b00;
			end
			else begin
				for (int h = 0; h < 2; h++)
					if (ack_hit[h]) begin
						done_q[h] <= 1'b1;
						pend_q[h] <= 1'b0;
					end
			end
			// writes finish on issue, reads wait for their id
			if (issue_half_i) begin
				if (bus_we_i)
					done_q[iss_u.f.half] <= 1'b1;
				else
					pend_q[iss_u.f.half] <= 1'b1;
			end
		end
	end

	// expected ids and returned data
	always_ff @(posedge clk_i) begin
		if (issue_half_i)
			exp_tid_q[iss_u.f.half] <= bus_tid_i;
		for (int h = 0; h < 2; h++)
			if (ack_hit[h])
				line_q[h*HW +: HW] <= bus_rd_dat_i;
	end

	assign halves_done_o = &done_q;

	// store bytes over the old line
	always_comb
		for (int b = 0; b < `DC_LINE_BYTES; b++)
			merged[b*8 +: 8] = svc_sel_i[b] ? svc_dat_i[b*8 +: 8] : cache_rd_dat_i[b*8 +: 8];

	// ============================================================
	// core and cache answers
	// ============================================================
	assign cache_load_o = fill_i;
	// a store only touches the cache on a cacheable hit
	assign cache_wr_o = fill_i || (finish_i && svc_we_i && hit_i && dce_i && cacheable_i);
	assign cache_wr_dat_o = fill_i ? line_q : merged;
	assign cache_wr_adr_o = wr_u.flat;

	assign cpu_ack_o = hit_ack_i || fill_i || finish_i;
	assign cpu_tid_o = svc_tid_i;
	assign cpu_dat_o = hit_ack_i ? hit_line_i : line_q;

endmodule

// ==== hw/dcache_miss_fsm.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_miss_fsm import dcache_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic dce_i,
	input logic head_v_i,
	input logic head_we_i,
	input adr_t head_adr_i,
	input line_sel_t head_sel_i,
	input line_t head_dat_i,
	input tid_t head_tid_i,
	input logic head_cacheable_i,
	input logic hit_i,
	input logic modified_i,
	input line_t cache_rd_dat_i,
	input adr_t victim_tag_i,
	input line_t victim_dat_i,
	input logic halves_done_i,
	output logic pop_o,
	output adr_t lookup_adr_o,
	output logic bus_cyc_o,
	output logic bus_we_o,
	output adr_t bus_adr_o,
	output half_sel_t bus_sel_o,
	output half_t bus_dat_o,
	output tid_t bus_tid_o,
	output logic issue_half_o,
	output logic skip_lo_o,
	output logic skip_hi_o,
	output logic svc_start_o,
	output logic dump_ack_o,
	output logic fill_o,
	output logic finish_o,
	output logic svc_we_o,
	output line_sel_t svc_sel_o,
	output line_t svc_dat_o,
	output adr_t svc_adr_o,
	output tid_t svc_tid_o,
	output line_t hit_line_o,
	output logic hit_ack_o
);

	localparam int HB = `DC_HALF_BYTES;
	localparam int HW = `DC_HALF_BYTES*8;

	dc_state_t state_q;
	// 0 and 1 issue halves, 2 waits for completion
	logic [1:0] cnt_q;
	tid_t tid_q;
	logic dump_done_q;

	bus_adr_u svc_u;
	bus_adr_u vic_u;
	logic cached;
	half_sel_t cur_sel;
	half_t cur_dat;
	half_t vic_dat;

	// the array is looked up with the head in idle, else the held request
	assign lookup_adr_o = (state_q == IDLE) ? head_adr_i : svc_adr_o;
	assign cached = dce_i && head_cacheable_i;

	always_comb begin
		svc_u.flat = svc_adr_o;
		vic_u.flat = victim_tag_i;
	end

	// half picked by the counter
	assign cur_sel = svc_sel_o[cnt_q[0]*HB +: HB];
	assign cur_dat = svc_dat_o[cnt_q[0]*HW +: HW];
	assign vic_dat = victim_dat_i[cnt_q[0]*HW +: HW];

	// put one half-line transaction on the bus next cycle
	task automatic issue(
		input logic we,
		input logic [DC_TAG_W-1:0] tag,
		input half_sel_t sel,
		input half_t dat
	);
		bus_adr_u a;
		a.f.tag = tag;
		a.f.half = cnt_q[0];
		a.f.ofs = '0;
		bus_cyc_o <= 1'b1;
		bus_we_o <= we;
		bus_adr_o <= a.flat;
		bus_sel_o <= sel;
		bus_dat_o <= dat;
		bus_tid_o <= tid_q;
		issue_half_o <= 1'b1;
		// ids roll over 1..15, skipping 0
		tid_q <= (tid_q == '1) ? tid_t'(1) : tid_q + tid_t'(1);
	endtask

	// ============================================================
	// service state machine
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= IDLE;
			cnt_q <= 2'd0;
			tid_q <= tid_t'(1);
			dump_done_q <= 1'b0;
			bus_cyc_o <= 1'b0;
			issue_half_o <= 1'b0;
			svc_start_o <= 1'b0;
			skip_lo_o <= 1'b0;
			skip_hi_o <= 1'b0;
			dump_ack_o <= 1'b0;
			fill_o <= 1'b0;
			finish_o <= 1'b0;
			hit_ack_o <= 1'b0;
			pop_o <= 1'b0;
		end
		else begin
			// strobes last one cycle
			bus_cyc_o <= 1'b0;
			issue_half_o <= 1'b0;
			svc_start_o <= 1'b0;
			fill_o <= 1'b0;
			finish_o <= 1'b0;
			hit_ack_o <= 1'b0;
			pop_o <= 1'b0;
			// dump ack trails the second dump write by a cycle
			dump_ack_o <= dump_done_q;
			dump_done_q <= 1'b0;
			case (state_q)
			IDLE:
				if (head_v_i) begin
					cnt_q <= 2'd0;
					if (!head_we_i && cached && hit_i) begin
						// read hit, answer straight from the array
						hit_ack_o <= 1'b1;
						pop_o <= 1'b1;
						state_q <= POST;
					end
					else if (!head_we_i && cached)
						state_q <= modified_i ? DUMP : LOAD;
					else
						state_q <= ACCESS;
				end
			DUMP: begin
				// write back the dirty victim, whole halves
				issue(1'b1, vic_u.f.tag, '1, vic_dat);
				cnt_q <= cnt_q + 2'd1;
				if (cnt_q[0]) begin
					cnt_q <= 2'd0;
					dump_done_q <= 1'b1;
					state_q <= LOAD;
				end
			end
			LOAD:
				if (!cnt_q[1]) begin
					if (cnt_q == 2'd0) begin
						svc_start_o <= 1'b1;
						skip_lo_o <= 1'b0;
						skip_hi_o <= 1'b0;
					end
					issue(1'b0, svc_u.f.tag, '1, '0);
					cnt_q <= cnt_q + 2'd1;
				end
				else if (halves_done_i) begin
					fill_o <= 1'b1;
					pop_o <= 1'b1;
					state_q <= POST;
				end
			ACCESS:
				if (!cnt_q[1]) begin
					if (cnt_q == 2'd0) begin
						svc_start_o <= 1'b1;
						skip_lo_o <= ~|svc_sel_o[HB-1:0];
						skip_hi_o <= ~|svc_sel_o[2*HB-1:HB];
					end
					// halves with no bytes selected stay off the bus
					if (|cur_sel)
						issue(svc_we_o, svc_u.f.tag, cur_sel, cur_dat);
					cnt_q <= cnt_q + 2'd1;
				end
				else if (halves_done_i) begin
					finish_o <= 1'b1;
					pop_o <= 1'b1;
					state_q <= POST;
				end
			POST:
				state_q <= IDLE;
			default:
				state_q <= IDLE;
			endcase
		end
	end

	// request and hit line are taken while idle
	always_ff @(posedge clk_i) begin
		if (state_q == IDLE) begin
			svc_we_o <= head_we_i;
			svc_sel_o <= head_sel_i;
			svc_dat_o <= head_dat_i;
			svc_adr_o <= head_adr_i;
			svc_tid_o <= head_tid_i;
			hit_line_o <= cache_rd_dat_i;
		end
	end

endmodule

// ==== hw/dcache_pkg.sv ====
`include "dcache_cfg.svh"

package dcache_pkg;

	// field widths of a byte address
	localparam int DC_OFS_W = $clog2(`DC_HALF_BYTES);
	localparam int DC_TAG_W = `DC_ADDR_W - $clog2(`DC_LINE_BYTES);

	// ============================================================
	// data and select words
	// ============================================================
	typedef logic [`DC_LINE_BYTES*8-1:0] line_t;
	typedef logic [`DC_HALF_BYTES*8-1:0] half_t;
	typedef logic [`DC_LINE_BYTES-1:0] line_sel_t;
	typedef logic [`DC_HALF_BYTES-1:0] half_sel_t;

	// id 0 never goes out on the bus
	typedef logic [`DC_TID_W-1:0] tid_t;
	typedef logic [`DC_ADDR_W-1:0] adr_t;

	// ============================================================
	// bus address, seen flat or split into line fields
	// ============================================================
	typedef struct packed {
		logic [DC_TAG_W-1:0] tag;
		logic half;
		logic [DC_OFS_W-1:0] ofs;
	} bus_adr_f_t;

	typedef union packed {
		adr_t flat;
		bus_adr_f_t f;
	} bus_adr_u;

	// service states of the miss fsm
	typedef enum logic [2:0] {
		IDLE,
		DUMP,
		LOAD,
		ACCESS,
		POST
	} dc_state_t;

endpackage

// ==== hw/dcache_req_queue.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_req_queue import dcache_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic cpu_cyc_i,
	input logic cpu_we_i,
	input adr_t cpu_adr_i,
	input line_sel_t cpu_sel_i,
	input line_t cpu_dat_i,
	input tid_t cpu_tid_i,
	input logic cpu_cacheable_i,
	input logic pop_i,
	output logic cpu_busy_o,
	output logic head_v_o,
	output logic head_we_o,
	output adr_t head_adr_o,
	output line_sel_t head_sel_o,
	output line_t head_dat_o,
	output tid_t head_tid_o,
	output logic head_cacheable_o
);

	localparam int QD = `DC_QUEUE_DEPTH;
	localparam int QW = $clog2(QD);

	// slot contents
	logic [QD-1:0] v_q;
	logic we_q [QD];
	adr_t adr_q [QD];
	line_sel_t sel_q [QD];
	line_t dat_q [QD];
	tid_t tid_q [QD];
	logic cach_q [QD];

	// slot held by the fsm while it is in service
	logic lock_q;
	logic [QW-1:0] idx_q;

	logic [QW-1:0] free_idx;
	logic [QW-1:0] sel_idx;
	logic [QW-1:0] head_idx;
	logic free_v;
	logic dup;
	logic push;

	// ============================================================
	// slot search
	// ============================================================
	// later slots overwrite earlier ones, so the highest index wins
	always_comb begin
		free_idx = '0;
		sel_idx = '0;
		free_v = 1'b0;
		dup = 1'b0;
		for (int i = 0; i < QD; i++) begin
			if (!v_q[i]) begin
				free_idx = QW'(i);
				free_v = 1'b1;
			end
			else begin
				sel_idx = QW'(i);
				// a second request with a live id is refused
				if (tid_q[i] == cpu_tid_i)
					dup = 1'b1;
			end
		end
	end

	assign push = cpu_cyc_i && free_v && !dup;
	assign cpu_busy_o = !free_v;

	// head stays on the serviced slot until it is popped
	assign head_idx = lock_q ? idx_q : sel_idx;
	assign head_v_o = |v_q;
	assign head_we_o = we_q[head_idx];
	assign head_adr_o = adr_q[head_idx];
	assign head_sel_o = sel_q[head_idx];
	assign head_dat_o = dat_q[head_idx];
	assign head_tid_o = tid_q[head_idx];
	assign head_cacheable_o = cach_q[head_idx];

	// valid bits and service lock
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			v_q <= '0;
			lock_q <= 1'b0;
			idx_q <= '0;
		end
		else begin
			// a free slot can never be the locked one
			if (push)
				v_q[free_idx] <= 1'b1;
			if (pop_i) begin
				v_q[idx_q] <= 1'b0;
				lock_q <= 1'b0;
			end
			else if (head_v_o && !lock_q) begin
				// fsm latches this same slot in idle
				lock_q <= 1'b1;
				idx_q <= sel_idx;
			end
		end
	end

	// request capture
	always_ff @(posedge clk_i) begin
		if (push) begin
			we_q[free_idx] <= cpu_we_i;
			adr_q[free_idx] <= cpu_adr_i;
			sel_q[free_idx] <= cpu_sel_i;
			dat_q[free_idx] <= cpu_dat_i;
			tid_q[free_idx] <= cpu_tid_i;
			cach_q[free_idx] <= cpu_cacheable_i;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the data cache controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module dcache_tb -o dcache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "compile failed, see build.log"
	exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see sim.log"
exit 1

// ==== tests/dcache_asserts.sv ====
`timescale 1ns/1ps

module dcache_asserts (
	input logic clk_i,
	input logic rst_i,
	input logic ack_i,
	input logic wr_i,
	input logic load_i,
	input logic bus_i,
	input logic dump_i
);

	// strobes come out of reset low
	a_ack_rst: assert property (@(posedge clk_i) rst_i |=> !ack_i)
		else $error("cpu ack high in reset");
	a_wr_rst: assert property (@(posedge clk_i) rst_i |=> !wr_i)
		else $error("cache write high in reset");
	a_bus_rst: assert property (@(posedge clk_i) rst_i |=> !bus_i)
		else $error("bus cycle high in reset");

	// a line fill is always a cache write
	a_load_wr: assert property (@(posedge clk_i) disable iff (rst_i) load_i |-> wr_i)
		else $error("cache load without cache write");

	// one pulse per dump
	a_dump_pulse: assert property (@(posedge clk_i) disable iff (rst_i) dump_i |=> !dump_i)
		else $error("dump ack held two cycles");

endmodule

bind dcache_ctrl_top dcache_asserts u_asserts (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.ack_i(cpu_ack_o),
	.wr_i(cache_wr_o),
	.load_i(cache_load_o),
	.bus_i(bus_cyc_o),
	.dump_i(dump_ack_o)
);

// ==== tests/dcache_clk_gen.sv ====
`timescale 1ns/1ps

module dcache_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	// 40 ns period
	int unsigned n_cyc = 0;

	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o;
	end

	// reset held over the first 10 rising edges
	always @(posedge clk_o)
		if (n_cyc < 10)
			n_cyc <= n_cyc + 1;

	assign rst_o = (n_cyc < 10);

endmodule

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb import dcache_pkg::*; ();

	logic clk, rst, dce;
	logic cpu_cyc, cpu_we, cpu_cacheable, cpu_busy, cpu_ack;
	adr_t cpu_adr, lookup_adr, victim_tag, cache_wr_adr, bus_adr;
	line_sel_t cpu_sel;
	line_t cpu_dat, cpu_rdat, cache_rd_dat, victim_dat, cache_wr_dat;
	tid_t cpu_tid, cpu_tid_ret, bus_tid, bus_ack_tid;
	logic hit, modified, cache_wr, cache_load, dump_ack;
	logic bus_cyc, bus_we, bus_ack;
	half_sel_t bus_sel;
	half_t bus_wdat, bus_rdat;

	integer seed = 32'h5727;
	int errors = 0;
	int timeouts = 0;

	dcache_clk_gen u_clk (.clk_o(clk), .rst_o(rst));

	dcache_ctrl_top dut0 (
		.clk_i(clk), .rst_i(rst), .dce_i(dce),
		.cpu_cyc_i(cpu_cyc), .cpu_we_i(cpu_we), .cpu_adr_i(cpu_adr),
		.cpu_sel_i(cpu_sel), .cpu_dat_i(cpu_dat), .cpu_tid_i(cpu_tid),
		.cpu_cacheable_i(cpu_cacheable), .cpu_busy_o(cpu_busy),
		.cpu_ack_o(cpu_ack), .cpu_tid_o(cpu_tid_ret), .cpu_dat_o(cpu_rdat),
		.lookup_adr_o(lookup_adr), .hit_i(hit), .modified_i(modified),
		.cache_rd_dat_i(cache_rd_dat), .victim_tag_i(victim_tag),
		.victim_dat_i(victim_dat), .cache_wr_o(cache_wr),
		.cache_wr_dat_o(cache_wr_dat), .cache_wr_adr_o(cache_wr_adr),
		.cache_load_o(cache_load), .dump_ack_o(dump_ack),
		.bus_cyc_o(bus_cyc), .bus_we_o(bus_we), .bus_adr_o(bus_adr),
		.bus_sel_o(bus_sel), .bus_dat_o(bus_wdat), .bus_tid_o(bus_tid),
		.bus_ack_i(bus_ack), .bus_tid_i(bus_ack_tid), .bus_dat_i(bus_rdat)
	);

	// ============================================================
	// cache array model, 16 sets of one line
	// ============================================================
	line_t c_dat [16];
	logic [27:0] c_tag [16];
	logic c_v [16];
	logic c_m [16];
	logic [3:0] c_idx;

	assign c_idx = lookup_adr[7:4];
	assign hit = c_v[c_idx] && (c_tag[c_idx] == lookup_adr[31:4]);
	assign modified = c_v[c_idx] && c_m[c_idx];
	assign cache_rd_dat = c_dat[c_idx];
	assign victim_tag = {c_tag[c_idx], 4'h0};
	assign victim_dat = c_dat[c_idx];

	// ============================================================
	// bus memory and event monitor
	// ============================================================
	half_t mem [adr_t];
	tid_t rq_tid [$];
	half_t rq_dat [$];
	int rq_due [$];
	logic hold = 1'b0;
	int cycle = 0;
	int ack_total = 0;
	int ack_cnt [16];
	int wr_cnt = 0;
	int load_cnt = 0;
	int dump_cnt = 0;
	int bus_wr_cnt = 0;
	int bus_rd_cnt = 0;
	line_t last_wr_dat;
	adr_t last_wr_adr;
	// core answer as it stood in the ack cycle
	line_t last_ack_dat;
	tid_t last_ack_tid;

	// untouched memory reads back a word tied to its whole address
	function automatic half_t pat(input adr_t a);
		return {a, a ^ 32'ha5a5_5a5a};
	endfunction

	function automatic half_t mem_rd(input adr_t a);
		return mem.exists(a) ? mem[a] : pat(a);
	endfunction

	function automatic line_t mem_line(input adr_t a);
		return {mem_rd({a[31:4], 4'h8}), mem_rd({a[31:4], 4'h0})};
	endfunction

	always @(posedge clk) begin
		half_t d;
		cycle <= cycle + 1;
		bus_ack <= 1'b0;
		if (bus_cyc) begin
			if (bus_we) begin
				// writes land on issue, byte by byte
				d = mem_rd(bus_adr);
				for (int b = 0; b < 8; b++)
					if (bus_sel[b])
						d[b*8 +: 8] = bus_wdat[b*8 +: 8];
				mem[bus_adr] = d;
				bus_wr_cnt <= bus_wr_cnt + 1;
			end
			else begin
				rq_tid.push_back(bus_tid);
				rq_dat.push_back(mem_rd(bus_adr));
				rq_due.push_back(cycle + 2);
				bus_rd_cnt <= bus_rd_cnt + 1;
			end
		end
		// read answers two cycles on, unless held back
		if (!hold && rq_tid.size() > 0 && rq_due[0] <= cycle) begin
			bus_ack <= 1'b1;
			bus_ack_tid <= rq_tid.pop_front();
			bus_rdat <= rq_dat.pop_front();
			void'(rq_due.pop_front());
		end
		if (cpu_ack) begin
			ack_total <= ack_total + 1;
			ack_cnt[cpu_tid_ret] <= ack_cnt[cpu_tid_ret] + 1;
			last_ack_dat <= cpu_rdat;
			last_ack_tid <= cpu_tid_ret;
		end
		if (cache_wr) begin
			wr_cnt <= wr_cnt + 1;
			last_wr_dat <= cache_wr_dat;
			last_wr_adr <= cache_wr_adr;
			c_dat[cache_wr_adr[7:4]] <= cache_wr_dat;
			c_tag[cache_wr_adr[7:4]] <= cache_wr_adr[31:4];
			c_v[cache_wr_adr[7:4]] <= 1'b1;
			// a fill is clean, a write-through store stays clean too
			c_m[cache_wr_adr[7:4]] <= 1'b0;
		end
		if (cache_load)
			load_cnt <= load_cnt + 1;
		if (dump_ack)
			dump_cnt <= dump_cnt + 1;
	end

	// ============================================================
	// compare tasks
	// ============================================================
	task automatic check_line(input string t, input line_t e, input line_t a);
		if (e !== a) begin
			errors++;
			$display("FAIL %s expected %h actual %h", t, e, a);
		end
	endtask

	task automatic check_adr(input string t, input adr_t e, input adr_t a);
		if (e !== a) begin
			errors++;
			$display("FAIL %s expected %h actual %h", t, e, a);
		end
	endtask

	task automatic check_tid(input string t, input tid_t e, input tid_t a);
		if (e !== a) begin
			errors++;
			$display("FAIL %s expected %0d actual %0d", t, e, a);
		end
	endtask

	task automatic check_bit(input string t, input logic e, input logic a);
		if (e !== a) begin
			errors++;
			$display("FAIL %s expected %b actual %b", t, e, a);
		end
	endtask

	task automatic check_count(input string t, input int e, input int a);
		if (e != a) begin
			errors++;
			$display("FAIL %s expected %0d actual %0d", t, e, a);
		end
	endtask

	// ============================================================
	// stimulus helpers
	// ============================================================
	function automatic line_t rnd_line();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic preload(input adr_t a, input line_t d, input logic m);
		c_dat[a[7:4]] <= d;
		c_tag[a[7:4]] <= a[31:4];
		c_v[a[7:4]] <= 1'b1;
		c_m[a[7:4]] <= m;
	endtask

	// one cpu_cyc cycle, left high for back to back requests
	task automatic drive_req(input logic we, input adr_t a, input line_sel_t s,
		input line_t d, input tid_t id, input logic cach);
		@(posedge clk);
		cpu_cyc <= 1'b1;
		cpu_we <= we;
		cpu_adr <= a;
		cpu_sel <= s;
		cpu_dat <= d;
		cpu_tid <= id;
		cpu_cacheable <= cach;
	endtask

	task automatic end_req();
		@(posedge clk);
		cpu_cyc <= 1'b0;
	endtask

	task automatic wait_acks(input string t, input int target);
		int n;
		n = 0;
		while (ack_total < target && n < 400) begin
			@(negedge clk);
			n++;
		end
		if (ack_total < target) begin
			timeouts++;
			$display("%s: no cpu ack arrived in time", t);
		end
	endtask

	// ============================================================
	// directed tests
	// ============================================================
	task automatic read_hit();
		line_t d;
		int b0;
		d = rnd_line();
		preload(32'h0000_1000, d, 1'b0);
		b0 = bus_rd_cnt + bus_wr_cnt;
		drive_req(1'b0, 32'h0000_1004, '1, '0, 4'd3, 1'b1);
		@(negedge clk);
		end_req();
		@(negedge clk);
		check_bit("read_hit early ack", 1'b0, cpu_ack);
		@(negedge clk);
		check_bit("read_hit ack", 1'b1, cpu_ack);
		check_line("read_hit data", d, cpu_rdat);
		check_tid("read_hit tid", 4'd3, cpu_tid_ret);
		repeat (4) @(negedge clk);
		check_count("read_hit bus", b0, bus_rd_cnt + bus_wr_cnt);
	endtask

	task automatic read_miss(input string t, input adr_t a, input logic dirty);
		line_t vic;
		adr_t va;
		int a0, r0, l0, d0;
		va = {8'h30, a[23:0]};
		vic = rnd_line();
		if (dirty)
			preload(va, vic, 1'b1);
		a0 = ack_total;
		r0 = bus_rd_cnt;
		l0 = load_cnt;
		d0 = dump_cnt;
		drive_req(1'b0, a, '1, '0, 4'd5, 1'b1);
		end_req();
		wait_acks(t, a0 + 1);
		check_line({t, " ack data"}, mem_line(a), last_ack_dat);
		check_tid({t, " tid"}, 4'd5, last_ack_tid);
		repeat (2) @(negedge clk);
		check_count({t, " acks"}, a0 + 1, ack_total);
		check_count({t, " bus reads"}, r0 + 2, bus_rd_cnt);
		check_count({t, " loads"}, l0 + 1, load_cnt);
		check_line({t, " fill"}, mem_line(a), last_wr_dat);
		check_adr({t, " fill address"}, {a[31:4], 4'h0}, last_wr_adr);
		if (dirty) begin
			check_count({t, " dump ack"}, d0 + 1, dump_cnt);
			check_line({t, " victim"}, vic, mem_line(va));
		end
	endtask

	task automatic store_hit();
		line_t old, sd, exp, exp_mem;
		line_sel_t s;
		int a0, w0, c0;
		old = rnd_line();
		sd = rnd_line();
		s = 16'h00f0;
		preload(32'h0000_5030, old, 1'b0);
		// expected line is old with the selected store bytes on top
		exp = old;
		// memory takes only the selected bytes, the rest stays as it was
		exp_mem = mem_line(32'h0000_5030);
		for (int b = 0; b < 16; b++)
			if (s[b]) begin
				exp[b*8 +: 8] = sd[b*8 +: 8];
				exp_mem[b*8 +: 8] = sd[b*8 +: 8];
			end
		a0 = ack_total;
		w0 = bus_wr_cnt;
		c0 = wr_cnt;
		drive_req(1'b1, 32'h0000_5030, s, sd, 4'd6, 1'b1);
		end_req();
		wait_acks("store_hit", a0 + 1);
		check_tid("store_hit tid", 4'd6, last_ack_tid);
		repeat (2) @(negedge clk);
		check_count("store_hit acks", a0 + 1, ack_total);
		check_count("store_hit bus writes", w0 + 1, bus_wr_cnt);
		check_line("store_hit bus data", exp_mem, mem_line(32'h0000_5030));
		check_count("store_hit cache writes", c0 + 1, wr_cnt);
		check_line("store_hit merge", exp, last_wr_dat);
		check_adr("store_hit cache address", 32'h0000_5030, last_wr_adr);
	endtask

	task automatic uncached_read();
		int a0, c0;
		preload(32'h0000_6040, rnd_line(), 1'b0);
		a0 = ack_total;
		c0 = wr_cnt;
		@(posedge clk);
		dce <= 1'b0;
		drive_req(1'b0, 32'h0000_6040, '1, '0, 4'd7, 1'b1);
		end_req();
		wait_acks("uncached_read", a0 + 1);
		check_line("uncached_read data", mem_line(32'h0000_6040), last_ack_dat);
		check_tid("uncached_read tid", 4'd7, last_ack_tid);
		repeat (2) @(negedge clk);
		check_count("uncached_read acks", a0 + 1, ack_total);
		check_count("uncached_read cache writes", c0, wr_cnt);
		@(posedge clk);
		dce <= 1'b1;
	endtask

	task automatic queue_full();
		int base [16];
		int a0;
		tid_t ids [6];
		ids = '{4'd1, 4'd2, 4'd1, 4'd3, 4'd4, 4'd5};
		base = ack_cnt;
		a0 = ack_total;
		@(posedge clk);
		hold <= 1'b1;
		// tid 1 twice, then one more than the queue holds
		for (int i = 0; i < 6; i++)
			drive_req(1'b0, 32'h0000_7000 + 32'(i) * 32'h10, '1, '0, ids[i], 1'b0);
		end_req();
		@(negedge clk);
		check_bit("queue_full busy", 1'b1, cpu_busy);
		@(posedge clk);
		hold <= 1'b0;
		wait_acks("queue_full", a0 + 4);
		repeat (20) @(negedge clk);
		for (int i = 1; i <= 4; i++)
			check_count($sformatf("queue_full acks tid %0d", i), base[i] + 1, ack_cnt[i]);
		check_count("queue_full acks tid 5", base[5], ack_cnt[5]);
		check_bit("queue_full busy after", 1'b0, cpu_busy);
	endtask

	// run limit
	initial begin
		#2_000_000;
		$display("simulation limit reached before the tests ended");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int n;
		dce <= 1'b1;
		cpu_cyc <= 1'b0;
		cpu_we <= 1'b0;
		cpu_adr <= '0;
		cpu_sel <= '0;
		cpu_dat <= '0;
		cpu_tid <= '0;
		cpu_cacheable <= 1'b0;
		bus_ack <= 1'b0;
		bus_ack_tid <= '0;
		bus_rdat <= '0;
		for (int i = 0; i < 16; i++) begin
			c_v[i] <= 1'b0;
			c_m[i] <= 1'b0;
			c_tag[i] <= '0;
			c_dat[i] <= '0;
			ack_cnt[i] <= 0;
		end
		n = 0;
		while (rst !== 1'b0 && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (rst !== 1'b0) begin
			timeouts++;
			$display("reset never released");
		end
		read_hit();
		read_miss("read_miss", 32'h0000_2010, 1'b0);
		read_miss("dirty_miss", 32'h0000_4020, 1'b1);
		store_hit();
		uncached_read();
		queue_full();
		repeat (5) @(posedge clk);
		$display("errors: %0d value, %0d timeout", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
